//--- cp0Pkg.sv
// ##########################################################################
// CP0 definitions
// Register numbers, exception kinds in priority order, the writeback
// fault report and Cause.ExcCode values
// ##########################################################################
package cp0Pkg;

    localparam logic [4:0] regAddrIndex    = 5'd0;
    localparam logic [4:0] regAddrEntryLo0 = 5'd2;
    localparam logic [4:0] regAddrEntryLo1 = 5'd3;
    localparam logic [4:0] regAddrBadVAddr = 5'd8;
    localparam logic [4:0] regAddrCount    = 5'd9;
    localparam logic [4:0] regAddrEntryHi  = 5'd10;
    localparam logic [4:0] regAddrCompare  = 5'd11;
    localparam logic [4:0] regAddrStatus   = 5'd12;
    localparam logic [4:0] regAddrCause    = 5'd13;
    localparam logic [4:0] regAddrEpc      = 5'd14;

    localparam int excCodeW = 5;

    // Highest priority first after excNone
    typedef enum logic [3:0] {
        excNone, excInterrupt, excAddrFetch, excReservedInstr, excSyscall,
        excBrk, excEret, excTrap, excOverflow, excAddrStore, excAddrLoad,
        excTlbRefill, excTlbInvalid, excTlbModified
    } excKindT;

    typedef struct packed {
        logic addrFetch;
        logic reservedInstr;
        logic syscall;
        logic brk;
        logic eret;
        logic trap;
        logic overflow;
        logic addrStore;
        logic addrLoad;
        logic tlbRefill;
        logic tlbInvalid;
        logic tlbModified;
    } faultT;

    typedef logic [excCodeW-1:0] excCodeT;

    localparam excCodeT codeInterrupt     = 5'h00;
    localparam excCodeT codeAddrFetch     = 5'h04;
    localparam excCodeT codeAddrLoad      = 5'h04;
    localparam excCodeT codeAddrStore     = 5'h05;
    localparam excCodeT codeReservedInstr = 5'h0a;
    localparam excCodeT codeSyscall       = 5'h08;
    localparam excCodeT codeBrk           = 5'h09;
    localparam excCodeT codeTrap          = 5'h0d;
    localparam excCodeT codeOverflow      = 5'h0c;
    localparam excCodeT codeTlbRefill     = 5'h02;
    localparam excCodeT codeTlbInvalid    = 5'h02;
    localparam excCodeT codeTlbModified   = 5'h01;

    localparam logic [31:0] excVector = 32'hBFC0_0380;

endpackage

//--- tlbPkg.sv
// ##########################################################################
// TLB geometry
// Entry count, index width and the field widths of one joint entry
// ##########################################################################
package tlbPkg;

    localparam int entries = 16;
    localparam int indexW  = 4;

    localparam int vpn2W  = 19;
    localparam int asidW  = 8;
    localparam int pfnW   = 20;
    localparam int cacheW = 3;

endpackage

//--- cp0Regs.sv
// ##########################################################################
// CP0 register file
// Software writes, exception recording, TLB probe and read captures,
// the Count/Compare timer and the combinational read port
// ##########################################################################
`timescale 1ns/1ps

module cp0Regs (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [5:0]                  hwInt,
    input  logic [4:0]                  rdAddr,
    output logic [31:0]                 rdData,
    input  logic                        wrEn,
    input  logic [4:0]                  wrAddr,
    input  logic [31:0]                 wrData,
    input  logic                        tlbp,
    input  logic                        tlbr,
    input  cp0Pkg::excKindT             excKind,
    input  logic [31:0]                 wbPc,
    input  logic                        wbInDelaySlot,
    input  logic [31:0]                 wbBadAddr,
    input  logic                        probeFound,
    input  logic [tlbPkg::indexW-1:0]   probeIndex,
    input  logic [tlbPkg::vpn2W-1:0]    rdVpn2,
    input  logic [tlbPkg::asidW-1:0]    rdAsid,
    input  logic [tlbPkg::pfnW-1:0]     rdPfn0,
    input  logic [tlbPkg::cacheW-1:0]   rdC0,
    input  logic                        rdD0,
    input  logic                        rdV0,
    input  logic [tlbPkg::pfnW-1:0]     rdPfn1,
    input  logic [tlbPkg::cacheW-1:0]   rdC1,
    input  logic                        rdD1,
    input  logic                        rdV1,
    input  logic                        rdG,
    output logic                        statusIe,
    output logic                        statusExl,
    output logic [7:0]                  statusIm,
    output logic [7:0]                  causeIp,
    output logic [31:0]                 epc,
    output logic [tlbPkg::indexW-1:0]   index,
    output logic [tlbPkg::vpn2W-1:0]    vpn2,
    output logic [tlbPkg::asidW-1:0]    asid,
    output logic [tlbPkg::pfnW-1:0]     pfn0,
    output logic [tlbPkg::cacheW-1:0]   c0,
    output logic                        d0,
    output logic                        v0,
    output logic                        g0,
    output logic [tlbPkg::pfnW-1:0]     pfn1,
    output logic [tlbPkg::cacheW-1:0]   c1,
    output logic                        d1,
    output logic                        v1,
    output logic                        g1
);

    logic            indexP;
    logic [31:0]     badVAddr;
    logic [31:0]     count;
    logic            countPhase;
    logic [31:0]     compare;
    logic            causeBd;
    logic            causeTi;
    cp0Pkg::excCodeT causeExcCode;
    logic            timerMatch;
    logic            excTaken;
    logic            recordEntry;

    logic wrIndex, wrLo0, wrLo1, wrCount, wrHi, wrCompare, wrStatus, wrCause, wrEpc;

    assign wrIndex   = wrEn && wrAddr == cp0Pkg::regAddrIndex;
    assign wrLo0     = wrEn && wrAddr == cp0Pkg::regAddrEntryLo0;
    assign wrLo1     = wrEn && wrAddr == cp0Pkg::regAddrEntryLo1;
    assign wrCount   = wrEn && wrAddr == cp0Pkg::regAddrCount;
    assign wrHi      = wrEn && wrAddr == cp0Pkg::regAddrEntryHi;
    assign wrCompare = wrEn && wrAddr == cp0Pkg::regAddrCompare;
    assign wrStatus  = wrEn && wrAddr == cp0Pkg::regAddrStatus;
    assign wrCause   = wrEn && wrAddr == cp0Pkg::regAddrCause;
    assign wrEpc     = wrEn && wrAddr == cp0Pkg::regAddrEpc;

    assign excTaken    = excKind != cp0Pkg::excNone;
    // Nested faults keep the first EPC and BD
    assign recordEntry = excTaken && excKind != cp0Pkg::excEret && !statusExl;
    assign timerMatch  = count == compare;

    // TLB-facing registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            indexP <= 1'b0;
            index  <= '0;
            {vpn2, asid} <= '0;
            {pfn0, c0, d0, v0, g0} <= '0;
            {pfn1, c1, d1, v1, g1} <= '0;
        end else begin
            if (tlbp) begin
                indexP <= !probeFound;
                index  <= probeIndex;
            end else if (wrIndex) begin
                index  <= wrData[tlbPkg::indexW-1:0];
            end
            if (tlbr) begin
                {vpn2, asid} <= {rdVpn2, rdAsid};
                {pfn0, c0, d0, v0, g0} <= {rdPfn0, rdC0, rdD0, rdV0, rdG};
                {pfn1, c1, d1, v1, g1} <= {rdPfn1, rdC1, rdD1, rdV1, rdG};
            end else begin
                if (wrHi) begin
                    vpn2 <= wrData[31:13];
                    asid <= wrData[7:0];
                end
                if (wrLo0) begin
                    {pfn0, c0, d0, v0, g0} <= wrData[25:0];
                end
                if (wrLo1) begin
                    {pfn1, c1, d1, v1, g1} <= wrData[25:0];
                end
            end
        end
    end

    // Count ticks on every second cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            countPhase <= 1'b0;
            count      <= '0;
            compare    <= '1;
            causeTi    <= 1'b0;
        end else begin
            if (wrCount) begin
                countPhase <= 1'b0;
                count      <= wrData;
            end else begin
                countPhase <= !countPhase;
                if (countPhase) begin
                    count <= count + 32'd1;
                end
            end
            if (wrCompare) begin
                compare <= wrData;
                causeTi <= 1'b0;
            end else if (timerMatch) begin
                causeTi <= 1'b1;
            end
        end
    end

    // Status, Cause, EPC and BadVAddr
    always_ff @(posedge clk) begin
        if (!rstN) begin
            statusIe     <= 1'b0;
            statusExl    <= 1'b0;
            statusIm     <= '0;
            causeIp      <= '0;
            causeBd      <= 1'b0;
            causeExcCode <= '0;
            epc          <= '0;
            badVAddr     <= '0;
        end else begin
            causeIp[7:2] <= hwInt | {timerMatch, 5'b0};
            if (wrCause) begin
                causeIp[1:0] <= wrData[9:8];
            end
            if (wrStatus) begin
                statusIe <= wrData[0];
                statusIm <= wrData[15:8];
            end
            if (excTaken) begin
                statusExl <= excKind != cp0Pkg::excEret;
            end else if (wrStatus) begin
                statusExl <= wrData[1];
            end
            if (recordEntry) begin
                causeBd <= wbInDelaySlot;
                epc     <= wbInDelaySlot ? wbPc - 32'd4 : wbPc;
            end else if (wrEpc && !excTaken) begin
                epc     <= wrData;
            end
            if (excKind == cp0Pkg::excAddrFetch) begin
                badVAddr <= wbPc;
            end else if (excKind == cp0Pkg::excAddrLoad || excKind == cp0Pkg::excAddrStore) begin
                badVAddr <= wbBadAddr;
            end
            case (excKind)
                cp0Pkg::excInterrupt:     causeExcCode <= cp0Pkg::codeInterrupt;
                cp0Pkg::excAddrFetch:     causeExcCode <= cp0Pkg::codeAddrFetch;
                cp0Pkg::excReservedInstr: causeExcCode <= cp0Pkg::codeReservedInstr;
                cp0Pkg::excSyscall:       causeExcCode <= cp0Pkg::codeSyscall;
                cp0Pkg::excBrk:           causeExcCode <= cp0Pkg::codeBrk;
                cp0Pkg::excTrap:          causeExcCode <= cp0Pkg::codeTrap;
                cp0Pkg::excOverflow:      causeExcCode <= cp0Pkg::codeOverflow;
                cp0Pkg::excAddrStore:     causeExcCode <= cp0Pkg::codeAddrStore;
                cp0Pkg::excAddrLoad:      causeExcCode <= cp0Pkg::codeAddrLoad;
                cp0Pkg::excTlbRefill:     causeExcCode <= cp0Pkg::codeTlbRefill;
                cp0Pkg::excTlbInvalid:    causeExcCode <= cp0Pkg::codeTlbInvalid;
                cp0Pkg::excTlbModified:   causeExcCode <= cp0Pkg::codeTlbModified;
                default:                  causeExcCode <= causeExcCode;
            endcase
        end
    end

    always_comb begin
        case (rdAddr)
            cp0Pkg::regAddrIndex:    rdData = {indexP, 27'b0, index};
            cp0Pkg::regAddrEntryLo0: rdData = {6'b0, pfn0, c0, d0, v0, g0};
            cp0Pkg::regAddrEntryLo1: rdData = {6'b0, pfn1, c1, d1, v1, g1};
            cp0Pkg::regAddrBadVAddr: rdData = badVAddr;
            cp0Pkg::regAddrCount:    rdData = count;
            cp0Pkg::regAddrEntryHi:  rdData = {vpn2, 5'b0, asid};
            cp0Pkg::regAddrCompare:  rdData = compare;
            // BEV is hardwired to 1
            cp0Pkg::regAddrStatus:   rdData = {9'b0, 1'b1, 6'b0, statusIm, 6'b0, statusExl, statusIe};
            cp0Pkg::regAddrCause:    rdData = {causeBd, causeTi, 14'b0, causeIp, 1'b0,
                                               causeExcCode, 2'b0};
            cp0Pkg::regAddrEpc:      rdData = epc;
            default:                 rdData = '0;
        endcase
    end

    wrAddrKnown: assert property (@(posedge clk) disable iff (!rstN)
        wrEn |-> !$isunknown(wrAddr))
        else $error("CP0 write with unknown address");

endmodule

//--- excDetect.sv
// ##########################################################################
// Writeback exception detector
// Ranks pending interrupts and fault flags into one exception kind
// and produces the pipeline flush and redirect address
// ##########################################################################
`timescale 1ns/1ps

module excDetect (
    input  logic             wbValid,
    input  cp0Pkg::faultT    wbFaults,
    input  logic             statusIe,
    input  logic             statusExl,
    input  logic [7:0]       statusIm,
    input  logic [7:0]       causeIp,
    input  logic [31:0]      epc,
    output cp0Pkg::excKindT  excKind,
    output logic             flush,
    output logic [31:0]      redirectPc
);

    logic intPending;

    assign intPending = statusIe && !statusExl && |(causeIp & statusIm);

    always_comb begin
        if (!wbValid)                    excKind = cp0Pkg::excNone;
        else if (intPending)             excKind = cp0Pkg::excInterrupt;
        else if (wbFaults.addrFetch)     excKind = cp0Pkg::excAddrFetch;
        else if (wbFaults.reservedInstr) excKind = cp0Pkg::excReservedInstr;
        else if (wbFaults.syscall)       excKind = cp0Pkg::excSyscall;
        else if (wbFaults.brk)           excKind = cp0Pkg::excBrk;
        else if (wbFaults.eret)          excKind = cp0Pkg::excEret;
        else if (wbFaults.trap)          excKind = cp0Pkg::excTrap;
        else if (wbFaults.overflow)      excKind = cp0Pkg::excOverflow;
        else if (wbFaults.addrStore)     excKind = cp0Pkg::excAddrStore;
        else if (wbFaults.addrLoad)      excKind = cp0Pkg::excAddrLoad;
        else if (wbFaults.tlbRefill)     excKind = cp0Pkg::excTlbRefill;
        else if (wbFaults.tlbInvalid)    excKind = cp0Pkg::excTlbInvalid;
        else if (wbFaults.tlbModified)   excKind = cp0Pkg::excTlbModified;
        else                             excKind = cp0Pkg::excNone;
    end

    assign flush = excKind != cp0Pkg::excNone;

    // eret returns to the saved PC, everything else goes to the vector
    assign redirectPc = excKind == cp0Pkg::excEret ? epc : cp0Pkg::excVector;

endmodule

//--- tlbArray.sv
// ##########################################################################
// Joint TLB, sixteen entries
// Combinational probe against EntryHi, indexed read and indexed write
// ##########################################################################
`timescale 1ns/1ps

module tlbArray (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        tlbwi,
    input  logic [tlbPkg::indexW-1:0]   index,
    input  logic [tlbPkg::vpn2W-1:0]    vpn2,
    input  logic [tlbPkg::asidW-1:0]    asid,
    input  logic [tlbPkg::pfnW-1:0]     pfn0,
    input  logic [tlbPkg::cacheW-1:0]   c0,
    input  logic                        d0,
    input  logic                        v0,
    input  logic                        g0,
    input  logic [tlbPkg::pfnW-1:0]     pfn1,
    input  logic [tlbPkg::cacheW-1:0]   c1,
    input  logic                        d1,
    input  logic                        v1,
    input  logic                        g1,
    output logic                        probeFound,
    output logic [tlbPkg::indexW-1:0]   probeIndex,
    output logic [tlbPkg::vpn2W-1:0]    rdVpn2,
    output logic [tlbPkg::asidW-1:0]    rdAsid,
    output logic [tlbPkg::pfnW-1:0]     rdPfn0,
    output logic [tlbPkg::cacheW-1:0]   rdC0,
    output logic                        rdD0,
    output logic                        rdV0,
    output logic [tlbPkg::pfnW-1:0]     rdPfn1,
    output logic [tlbPkg::cacheW-1:0]   rdC1,
    output logic                        rdD1,
    output logic                        rdV1,
    output logic                        rdG
);

    localparam int n = tlbPkg::entries;

    logic [tlbPkg::vpn2W-1:0]  eVpn2 [n];
    logic [tlbPkg::asidW-1:0]  eAsid [n];
    logic                      eG    [n];
    // Both halves packed as {pfn, c, d, v}
    logic [tlbPkg::pfnW+tlbPkg::cacheW+1:0] eLo0 [n];
    logic [tlbPkg::pfnW+tlbPkg::cacheW+1:0] eLo1 [n];
    logic [n-1:0]              match;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < n; i++) begin
                // Distinct VPN2 per entry keeps reset entries apart
                eVpn2[i] <= tlbPkg::vpn2W'(i);
                eAsid[i] <= '0;
                eG[i]    <= 1'b0;
                eLo0[i]  <= '0;
                eLo1[i]  <= '0;
            end
        end else if (tlbwi) begin
            eVpn2[index] <= vpn2;
            eAsid[index] <= asid;
            eG[index]    <= g0 & g1;
            eLo0[index]  <= {pfn0, c0, d0, v0};
            eLo1[index]  <= {pfn1, c1, d1, v1};
        end
    end

    always_comb begin
        probeIndex = '0;
        for (int i = 0; i < n; i++) begin
            match[i] = eVpn2[i] == vpn2 && (eG[i] || eAsid[i] == asid);
            if (match[i]) begin
                probeIndex = tlbPkg::indexW'(i);
            end
        end
    end

    assign probeFound = |match;

    assign rdVpn2 = eVpn2[index];
    assign rdAsid = eAsid[index];
    assign rdG    = eG[index];
    assign {rdPfn0, rdC0, rdD0, rdV0} = eLo0[index];
    assign {rdPfn1, rdC1, rdD1, rdV1} = eLo1[index];

    singleMatch: assert property (@(posedge clk) disable iff (!rstN) $onehot0(match))
        else $error("TLB probe hit more than one entry");

endmodule

//--- cp0Top.sv
// ##########################################################################
// CP0 top level
// Register file, writeback exception detector and joint TLB
// ##########################################################################
`timescale 1ns/1ps

module cp0Top (
    input  logic          clk,
    input  logic          rstN,
    input  logic [4:0]    rdAddr,
    output logic [31:0]   rdData,
    input  logic          wrEn,
    input  logic [4:0]    wrAddr,
    input  logic [31:0]   wrData,
    input  logic          tlbp,
    input  logic          tlbr,
    input  logic          tlbwi,
    input  logic          wbValid,
    input  cp0Pkg::faultT wbFaults,
    input  logic [31:0]   wbPc,
    input  logic          wbInDelaySlot,
    input  logic [31:0]   wbBadAddr,
    input  logic [5:0]    hwInt,
    output logic          flush,
    output logic [31:0]   redirectPc
);

    cp0Pkg::excKindT excKind;
    logic            statusIe;
    logic            statusExl;
    logic [7:0]      statusIm;
    logic [7:0]      causeIp;
    logic [31:0]     epc;

    // CP0 to TLB
    logic [tlbPkg::indexW-1:0] index;
    logic [tlbPkg::vpn2W-1:0]  vpn2;
    logic [tlbPkg::asidW-1:0]  asid;
    logic [tlbPkg::pfnW-1:0]   pfn0, pfn1;
    logic [tlbPkg::cacheW-1:0] c0, c1;
    logic                      d0, v0, g0, d1, v1, g1;

    // TLB to CP0
    logic                      probeFound;
    logic [tlbPkg::indexW-1:0] probeIndex;
    logic [tlbPkg::vpn2W-1:0]  rdVpn2;
    logic [tlbPkg::asidW-1:0]  rdAsid;
    logic [tlbPkg::pfnW-1:0]   rdPfn0, rdPfn1;
    logic [tlbPkg::cacheW-1:0] rdC0, rdC1;
    logic                      rdD0, rdV0, rdD1, rdV1, rdG;

    cp0Regs regs0 (.*);

    excDetect exc0 (.*);

    tlbArray tlb0 (.*);

endmodule

//--- tbCp0.sv
// ##########################################################################
// CP0 testbench
// Directed tests for register access, exception entry and return,
// fault ranking, interrupts, the Count/Compare timer and TLB instructions
// ##########################################################################
`timescale 1ns/1ps

module tbCp0;

    localparam int periodNs      = 10;
    localparam int resetCycles   = 5;
    localparam int testCount     = 6;
    localparam int cyclesPerTest = 60;
    localparam int marginCycles  = 50;
    localparam int pollLimit     = 40;
    localparam logic [31:0] vectorPc = 32'hBFC0_0380;

    logic          clk;
    logic          rstN;
    logic [4:0]    rdAddr;
    logic [31:0]   rdData;
    logic          wrEn;
    logic [4:0]    wrAddr;
    logic [31:0]   wrData;
    logic          tlbp;
    logic          tlbr;
    logic          tlbwi;
    logic          wbValid;
    cp0Pkg::faultT wbFaults;
    logic [31:0]   wbPc;
    logic          wbInDelaySlot;
    logic [31:0]   wbBadAddr;
    logic [5:0]    hwInt;
    logic          flush;
    logic [31:0]   redirectPc;
    integer        seed = 27578;

    cp0Top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Budget covers reset plus every test at its worst-case length
    initial begin
        #((resetCycles + testCount * cyclesPerTest + marginCycles) * periodNs);
        $display("Watchdog expired before the tests finished");
        stopRun();
    end

    task automatic stopRun;
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkKind(input string name, input cp0Pkg::excCodeT expected,
                             input cp0Pkg::excCodeT actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    // BEV at bit 22, IM at 15:8, EXL at 1 and IE at 0 in Status
    function automatic logic [31:0] statusWord(input logic [7:0] im, input logic exl,
                                               input logic ie);
        return 32'h0040_0000 | {16'b0, im, 6'b0, exl, ie};
    endfunction

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        wrEn   = 1'b1;
        wrAddr = addr;
        wrData = data;
        @(negedge clk);
        wrEn   = 1'b0;
    endtask

    task automatic readReg(input logic [4:0] addr, output logic [31:0] data);
        rdAddr = addr;
        #1;
        data = rdData;
        @(negedge clk);
    endtask

    task automatic pulseTlb(input logic probe, input logic read, input logic write);
        tlbp  = probe;
        tlbr  = read;
        tlbwi = write;
        @(negedge clk);
        {tlbp, tlbr, tlbwi} = 3'b000;
    endtask

    // Flush and redirect are combinational, checked before the clock edge
    task automatic retire(input string name, input cp0Pkg::faultT faults,
                          input logic [31:0] pc, input logic inDelaySlot,
                          input logic [31:0] badAddr, input logic expFlush,
                          input logic [31:0] expRedirect);
        wbValid       = 1'b1;
        wbFaults      = faults;
        wbPc          = pc;
        wbInDelaySlot = inDelaySlot;
        wbBadAddr     = badAddr;
        #1;
        checkBit({name, " flush"}, expFlush, flush);
        if (expFlush) begin
            checkWord({name, " redirect"}, expRedirect, redirectPc);
        end
        @(negedge clk);
        wbValid       = 1'b0;
        wbFaults      = '0;
        wbInDelaySlot = 1'b0;
    endtask

    task automatic retireAndCode(input string name, input cp0Pkg::faultT faults,
                                 input logic [31:0] pc, input logic [31:0] badAddr,
                                 input cp0Pkg::excCodeT expCode);
        logic [31:0] got;
        retire(name, faults, pc, 1'b0, badAddr, 1'b1, vectorPc);
        readReg(cp0Pkg::regAddrCause, got);
        checkKind({name, " ExcCode"}, expCode, got[6:2]);
    endtask

    task automatic testWriteRead;
        logic [31:0] data;
        logic [31:0] got;
        readReg(cp0Pkg::regAddrCause, got);
        checkWord("reset Cause", 32'h0, got);
        readReg(cp0Pkg::regAddrStatus, got);
        checkWord("reset Status", 32'h0040_0000, got);
        data = $random(seed);
        writeReg(cp0Pkg::regAddrEpc, data);
        readReg(cp0Pkg::regAddrEpc, got);
        checkWord("EPC write", data, got);
        data = $random(seed);
        writeReg(cp0Pkg::regAddrCompare, data);
        readReg(cp0Pkg::regAddrCompare, got);
        checkWord("Compare write", data, got);
        data = $random(seed);
        writeReg(cp0Pkg::regAddrStatus, data);
        readReg(cp0Pkg::regAddrStatus, got);
        checkWord("Status write", statusWord(data[15:8], data[1], data[0]), got);
        writeReg(cp0Pkg::regAddrStatus, 32'h0);
    endtask

    task automatic testException;
        cp0Pkg::faultT f;
        logic [31:0]   pc;
        logic [31:0]   dsPc;
        logic [31:0]   got;
        f = '0;
        f.syscall = 1'b1;
        pc = $random(seed) & 32'hffff_fffc;
        retireAndCode("syscall", f, pc, 32'h0, 5'h08);
        readReg(cp0Pkg::regAddrEpc, got);
        checkWord("syscall EPC", pc, got);
        readReg(cp0Pkg::regAddrStatus, got);
        checkBit("syscall EXL", 1'b1, got[1]);
        writeReg(cp0Pkg::regAddrStatus, 32'h0);
        dsPc = $random(seed) & 32'hffff_fffc;
        retire("delay slot", f, dsPc, 1'b1, 32'h0, 1'b1, vectorPc);
        readReg(cp0Pkg::regAddrEpc, got);
        checkWord("delay slot EPC", dsPc - 32'd4, got);
        readReg(cp0Pkg::regAddrCause, got);
        checkBit("delay slot BD", 1'b1, got[31]);
        f = '0;
        f.brk = 1'b1;
        retireAndCode("nested brk", f, pc, 32'h0, 5'h09);
        readReg(cp0Pkg::regAddrEpc, got);
        checkWord("nested EPC", dsPc - 32'd4, got);
        f = '0;
        f.eret = 1'b1;
        retire("eret", f, pc, 1'b0, 32'h0, 1'b1, dsPc - 32'd4);
        readReg(cp0Pkg::regAddrStatus, got);
        checkBit("eret EXL", 1'b0, got[1]);
    endtask

    task automatic testPriority;
        cp0Pkg::faultT f;
        logic [31:0]   pc;
        logic [31:0]   bad;
        logic [31:0]   got;
        pc  = $random(seed) & 32'hffff_fffc;
        bad = $random(seed);
        f = '0;
        {f.overflow, f.addrLoad, f.tlbRefill} = 3'b111;
        retireAndCode("overflow rank", f, pc, bad, 5'h0c);
        f = '0;
        {f.reservedInstr, f.syscall, f.trap} = 3'b111;
        retireAndCode("reserved rank", f, pc, bad, 5'h0a);
        f = '0;
        {f.addrStore, f.tlbModified} = 2'b11;
        retireAndCode("store rank", f, pc, bad, 5'h05);
        f = '0;
        f.addrLoad = 1'b1;
        retireAndCode("addrLoad", f, pc, bad, 5'h04);
        readReg(cp0Pkg::regAddrBadVAddr, got);
        checkWord("addrLoad BadVAddr", bad, got);
        pc  = $random(seed);
        bad = $random(seed);
        {f.addrFetch, f.addrLoad} = 2'b11;
        retireAndCode("addrFetch", f, pc, bad, 5'h04);
        readReg(cp0Pkg::regAddrBadVAddr, got);
        checkWord("addrFetch BadVAddr", pc, got);
    endtask

    task automatic testInterrupt;
        logic [31:0] got;
        // IE and IM2
        writeReg(cp0Pkg::regAddrStatus, 32'h0000_0401);
        hwInt = 6'b000001;
        @(negedge clk);
        readReg(cp0Pkg::regAddrCause, got);
        checkBit("Cause IP2", 1'b1, got[10]);
        retireAndCode("interrupt", '0, 32'h0000_1000, 32'h0, 5'h00);
        readReg(cp0Pkg::regAddrStatus, got);
        checkBit("interrupt EXL", 1'b1, got[1]);
        writeReg(cp0Pkg::regAddrStatus, 32'h0000_0400);
        retire("masked interrupt", '0, 32'h0000_1004, 1'b0, 32'h0, 1'b0, 32'h0);
        hwInt = 6'b000000;
        @(negedge clk);
    endtask

    task automatic testTimer;
        logic [31:0] n;
        logic [31:0] got;
        int          polls;
        n = $random(seed);
        writeReg(cp0Pkg::regAddrCompare, n);
        writeReg(cp0Pkg::regAddrCount, n - 32'd4);
        readReg(cp0Pkg::regAddrCause, got);
        checkBit("TI before match", 1'b0, got[30]);
        polls = 0;
        while (!got[30]) begin
            if (polls == pollLimit) begin
                $display("Timer interrupt not seen within %0d polls of Cause", pollLimit);
                stopRun();
            end else begin
                readReg(cp0Pkg::regAddrCause, got);
                polls++;
            end
        end
        // Move Compare far from Count so TI stays clear
        writeReg(cp0Pkg::regAddrCompare, n ^ 32'h8000_0000);
        readReg(cp0Pkg::regAddrCause, got);
        checkBit("TI after Compare write", 1'b0, got[30]);
    endtask

    task automatic testTlb;
        logic [31:0] hi;
        logic [31:0] lo0;
        logic [31:0] lo1;
        logic [31:0] word;
        logic [31:0] got;
        logic [3:0]  idx;
        // VPN2 top bit set keeps it away from the reset entries
        hi   = ($random(seed) & 32'hffff_e0ff) | 32'h8000_0000;
        lo0  = $random(seed) & 32'h03ff_fffe;
        lo1  = $random(seed) & 32'h03ff_fffe;
        word = $random(seed);
        idx  = word[3:0];
        writeReg(cp0Pkg::regAddrEntryHi, hi);
        writeReg(cp0Pkg::regAddrEntryLo0, lo0);
        writeReg(cp0Pkg::regAddrEntryLo1, lo1);
        writeReg(cp0Pkg::regAddrIndex, {28'b0, idx});
        readReg(cp0Pkg::regAddrEntryHi, got);
        checkWord("EntryHi write", hi, got);
        pulseTlb(1'b0, 1'b0, 1'b1);
        pulseTlb(1'b1, 1'b0, 1'b0);
        readReg(cp0Pkg::regAddrIndex, got);
        checkWord("tlbp hit Index", {28'b0, idx}, got);
        writeReg(cp0Pkg::regAddrEntryHi, hi ^ 32'h0000_2000);
        pulseTlb(1'b1, 1'b0, 1'b0);
        readReg(cp0Pkg::regAddrIndex, got);
        checkBit("tlbp miss P", 1'b1, got[31]);
        writeReg(cp0Pkg::regAddrIndex, {28'b0, idx});
        writeReg(cp0Pkg::regAddrEntryLo0, 32'h0);
        writeReg(cp0Pkg::regAddrEntryLo1, 32'h0);
        pulseTlb(1'b0, 1'b1, 1'b0);
        readReg(cp0Pkg::regAddrEntryHi, got);
        checkWord("tlbr EntryHi", hi, got);
        readReg(cp0Pkg::regAddrEntryLo0, got);
        checkWord("tlbr EntryLo0", lo0, got);
        readReg(cp0Pkg::regAddrEntryLo1, got);
        checkWord("tlbr EntryLo1", lo1, got);
    endtask

    initial begin
        rstN          = 1'b0;
        rdAddr        = '0;
        wrEn          = 1'b0;
        wrAddr        = '0;
        wrData        = '0;
        {tlbp, tlbr, tlbwi} = 3'b000;
        wbValid       = 1'b0;
        wbFaults      = '0;
        wbPc          = '0;
        wbInDelaySlot = 1'b0;
        wbBadAddr     = '0;
        hwInt         = '0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        testWriteRead();
        testException();
        testPriority();
        testInterrupt();
        testTimer();
        testTlb();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- files.f
cp0Pkg.sv
tlbPkg.sv
cp0Regs.sv
excDetect.sv
tlbArray.sv
cp0Top.sv
tbCp0.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tbCp0
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

# The run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
